// ==== design/fb_pkg.sv ====
// shared geometry, bank names and request structs for the triple-buffered frame store
package fb_pkg;

    // frame geometry
    localparam int frame_w  = 16;
    localparam int frame_h  = 16;
    localparam int frame_px = frame_w * frame_h;

    localparam int pixel_w  = 16;
    localparam int coord_w  = 8;
    localparam int addr_w   = $clog2(frame_px);

    // column bits of an address, frame_w is a power of two
    localparam int col_bits = $clog2(frame_w);

    // last legal coordinates
    localparam logic [coord_w-1:0] x_last = coord_w'(frame_w - 1);
    localparam logic [coord_w-1:0] y_last = coord_w'(frame_h - 1);

    // buffer names, code 2'd3 never appears
    typedef enum logic [1:0] {
        bank0 = 2'd0,
        bank1 = 2'd1,
        bank2 = 2'd2
    } bank_e;

    // writer to memory
    typedef struct packed {
        bank_e               bank;
        logic [addr_w-1:0]   addr;
        logic [pixel_w-1:0]  data;
    } wr_req_t;

    // scanner to memory
    typedef struct packed {
        bank_e               bank;
        logic [addr_w-1:0]   addr;
    } rd_req_t;

    // description of one output pixel
    typedef struct packed {
        logic [coord_w-1:0]  x;
        logic [coord_w-1:0]  y;
        logic                frame_start;
        logic                line_start;
    } scan_info_t;

    // raster address, row times frame_w plus column
    function automatic logic [addr_w-1:0] pixel_addr(
        input logic [coord_w-1:0] x,
        input logic [coord_w-1:0] y
    );
        logic [addr_w-1:0] row;
        logic [addr_w-1:0] col;
        row = addr_w'(y) << col_bits;
        col = addr_w'(x);
        return row + col;
    endfunction

endpackage

// ==== design/pixel_writer.sv ====
// range check of pixel writes and registered bank write requests for the frame memory
`timescale 1ns/1ps

module pixel_writer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_en,
    input  logic [fb_pkg::coord_w-1:0] wr_x,
    input  logic [fb_pkg::coord_w-1:0] wr_y,
    input  logic [fb_pkg::pixel_w-1:0] pixel_in,
    input  fb_pkg::bank_e              write_bank,
    output logic                       wr_strobe,
    output fb_pkg::wr_req_t            wr_req
);

    logic                      in_range;
    logic                      accept;
    logic [fb_pkg::addr_w-1:0] wr_addr;

    // out-of-frame writes are dropped here and nowhere else
    assign in_range = (wr_x <= fb_pkg::x_last) && (wr_y <= fb_pkg::y_last);
    assign accept   = wr_en && in_range;
    assign wr_addr  = fb_pkg::pixel_addr(wr_x, wr_y);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_strobe <= 1'b0;
        end else begin
            wr_strobe <= accept;
        end
    end

    // bank is latched with the pixel so a later swap cannot redirect it
    always_ff @(posedge clk) begin
        if (accept) begin
            wr_req.bank <= write_bank;
            wr_req.addr <= wr_addr;
            wr_req.data <= pixel_in;
        end
    end

    // row and column of every issued address give back the in-frame write one cycle earlier
    a_req_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_strobe |-> ($past(wr_en)
                       && int'(wr_req.addr) / fb_pkg::frame_w == int'($past(wr_y))
                       && int'(wr_req.addr) % fb_pkg::frame_w == int'($past(wr_x)))
    ) else $error("write request outside the frame, addr %0d", wr_req.addr);

endmodule

// ==== design/buffer_rotator.sv ====
// role registers of the three frame buffers, rotated by the swap pulse
`timescale 1ns/1ps

module buffer_rotator (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          buffer_swap,
    output fb_pkg::bank_e write_bank,
    output fb_pkg::bank_e display_bank
);

    fb_pkg::bank_e ready_bank;

    // ready -> display, write -> ready, display -> write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display_bank <= fb_pkg::bank0;
            write_bank   <= fb_pkg::bank1;
            ready_bank   <= fb_pkg::bank2;
        end else if (buffer_swap) begin
            display_bank <= ready_bank;
            ready_bank   <= write_bank;
            write_bank   <= display_bank;
        end
    end

    // roles form a permutation of the three legal banks
    a_roles_distinct: assert property (
        @(posedge clk) disable iff (!rst_n)
        write_bank != ready_bank
        && write_bank != display_bank
        && ready_bank != display_bank
        && write_bank != 2'd3
        && ready_bank != 2'd3
        && display_bank != 2'd3
    ) else $error("buffer roles overlap or illegal: w=%0d r=%0d d=%0d",
                  write_bank, ready_bank, display_bank);

endmodule

// ==== design/frame_memory.sv ====
// three pixel banks with one write port and one registered read port
`timescale 1ns/1ps

module frame_memory (
    input  logic                       clk,
    input  logic                       wr_strobe,
    input  fb_pkg::wr_req_t            wr_req,
    input  logic                       rd_strobe,
    input  fb_pkg::rd_req_t            rd_req,
    output logic [fb_pkg::pixel_w-1:0] rd_data
);

    logic [fb_pkg::pixel_w-1:0] mem0 [fb_pkg::frame_px];
    logic [fb_pkg::pixel_w-1:0] mem1 [fb_pkg::frame_px];
    logic [fb_pkg::pixel_w-1:0] mem2 [fb_pkg::frame_px];

    // write steered by the bank field
    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            case (wr_req.bank)
                fb_pkg::bank0: mem0[wr_req.addr] <= wr_req.data;
                fb_pkg::bank1: mem1[wr_req.addr] <= wr_req.data;
                fb_pkg::bank2: mem2[wr_req.addr] <= wr_req.data;
                default: begin
                end
            endcase
        end
    end

    // synchronous read, data holds between strobes
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            case (rd_req.bank)
                fb_pkg::bank0: rd_data <= mem0[rd_req.addr];
                fb_pkg::bank1: rd_data <= mem1[rd_req.addr];
                fb_pkg::bank2: rd_data <= mem2[rd_req.addr];
                default:       rd_data <= '0;
            endcase
        end
    end

    // writer and scanner come from different roles, so never the same bank
    a_no_bank_clash: assert property (
        @(posedge clk)
        (wr_strobe && rd_strobe) |-> (wr_req.bank != rd_req.bank)
    ) else $error("read and write on bank %0d in the same cycle", rd_req.bank);

endmodule

// ==== design/raster_scanner.sv ====
// scan-out side: raster coordinates, bank read requests and per-pixel scan flags
`timescale 1ns/1ps

module raster_scanner (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               rd_en,
    input  logic               buffer_swap,
    input  fb_pkg::bank_e      display_bank,
    output logic               rd_strobe,
    output fb_pkg::rd_req_t    rd_req,
    output logic               pixel_valid,
    output fb_pkg::scan_info_t scan_info
);

    logic [fb_pkg::coord_w-1:0] x;
    logic [fb_pkg::coord_w-1:0] y;
    logic                       x_end;
    logic                       y_end;

    // registered description of the pixel in flight
    logic [fb_pkg::coord_w-1:0] x_q;
    logic [fb_pkg::coord_w-1:0] y_q;
    logic                       frame_start_q;
    logic                       line_start_q;

    assign x_end = (x == fb_pkg::x_last);
    assign y_end = (y == fb_pkg::y_last);

    // a read coinciding with a swap is dropped
    assign rd_strobe = rd_en && !buffer_swap;

    always_comb begin
        rd_req.bank = display_bank;
        rd_req.addr = fb_pkg::pixel_addr(x, y);
    end

    // swap restarts the frame and wins over rd_en
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (buffer_swap) begin
            x <= '0;
            y <= '0;
        end else if (rd_en) begin
            if (x_end) begin
                x <= '0;
                y <= y_end ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // flags are single-cycle pulses aligned with the returning data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_valid   <= 1'b0;
            frame_start_q <= 1'b0;
            line_start_q  <= 1'b0;
        end else begin
            pixel_valid   <= rd_strobe;
            frame_start_q <= rd_strobe && (x == '0) && (y == '0);
            line_start_q  <= rd_strobe && (x == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            x_q <= x;
            y_q <= y;
        end
    end

    always_comb begin
        scan_info.x           = x_q;
        scan_info.y           = y_q;
        scan_info.frame_start = frame_start_q;
        scan_info.line_start  = line_start_q;
    end

    // counters never leave the frame
    a_scan_in_frame: assert property (
        @(posedge clk) disable iff (!rst_n)
        (x <= fb_pkg::x_last) && (y <= fb_pkg::y_last)
    ) else $error("scan position out of frame (%0d,%0d)", x, y);

endmodule

// ==== design/triple_buffer_codec.sv ====
// top of the triple-buffered frame store, joins writer, role rotator, memory and scanner
`timescale 1ns/1ps

module triple_buffer_codec (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [fb_pkg::pixel_w-1:0] pixel_in,
    input  logic                       wr_en,
    input  logic [fb_pkg::coord_w-1:0] wr_x,
    input  logic [fb_pkg::coord_w-1:0] wr_y,
    input  logic                       buffer_swap,
    input  logic                       rd_en,
    output logic [fb_pkg::pixel_w-1:0] pixel_out,
    output logic                       pixel_valid,
    output logic [fb_pkg::coord_w-1:0] out_x,
    output logic [fb_pkg::coord_w-1:0] out_y,
    output logic                       frame_start,
    output logic                       line_start
);

    fb_pkg::bank_e      write_bank;
    fb_pkg::bank_e      display_bank;
    logic               wr_strobe;
    fb_pkg::wr_req_t    wr_req;
    logic               rd_strobe;
    fb_pkg::rd_req_t    rd_req;
    fb_pkg::scan_info_t scan_info;

    pixel_writer u_pixel_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_x       (wr_x),
        .wr_y       (wr_y),
        .pixel_in   (pixel_in),
        .write_bank (write_bank),
        .wr_strobe  (wr_strobe),
        .wr_req     (wr_req)
    );

    buffer_rotator u_buffer_rotator (
        .clk          (clk),
        .rst_n        (rst_n),
        .buffer_swap  (buffer_swap),
        .write_bank   (write_bank),
        .display_bank (display_bank)
    );

    frame_memory u_frame_memory (
        .clk       (clk),
        .wr_strobe (wr_strobe),
        .wr_req    (wr_req),
        .rd_strobe (rd_strobe),
        .rd_req    (rd_req),
        .rd_data   (pixel_out)
    );

    raster_scanner u_raster_scanner (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_en        (rd_en),
        .buffer_swap  (buffer_swap),
        .display_bank (display_bank),
        .rd_strobe    (rd_strobe),
        .rd_req       (rd_req),
        .pixel_valid  (pixel_valid),
        .scan_info    (scan_info)
    );

    assign out_x       = scan_info.x;
    assign out_y       = scan_info.y;
    assign frame_start = scan_info.frame_start;
    assign line_start  = scan_info.line_start;

endmodule

// ==== bench/triple_buffer_codec_tb.sv ====
// testbench for the triple-buffered frame store, random frames and scans checked against a frame model
`timescale 1ns/1ps

module triple_buffer_codec_tb;

    localparam int clk_period = 100;
    localparam int coord_span = 1 << fb_pkg::coord_w;

    // upper bound of driven cycles, scans may insert one idle cycle per pixel
    localparam int scan_cycles  = 2 * (4 * fb_pkg::frame_px + fb_pkg::frame_w + 80);
    localparam int write_cycles = 4 * fb_pkg::frame_px + 64;
    localparam int stim_cycles  = scan_cycles + write_cycles + 32;
    localparam int watchdog_ns  = 20 * stim_cycles * clk_period + 10000;

    typedef struct packed {
        logic                       valid;
        logic [fb_pkg::coord_w-1:0] x;
        logic [fb_pkg::coord_w-1:0] y;
        logic [fb_pkg::pixel_w-1:0] data;
        logic                       fs;
        logic                       ls;
    } expect_t;

    logic                       clk;
    logic                       rst_n;
    logic [fb_pkg::pixel_w-1:0] pixel_in;
    logic                       wr_en;
    logic [fb_pkg::coord_w-1:0] wr_x;
    logic [fb_pkg::coord_w-1:0] wr_y;
    logic                       buffer_swap;
    logic                       rd_en;
    logic [fb_pkg::pixel_w-1:0] pixel_out;
    logic                       pixel_valid;
    logic [fb_pkg::coord_w-1:0] out_x;
    logic [fb_pkg::coord_w-1:0] out_y;
    logic                       frame_start;
    logic                       line_start;

    // reference frames, roles and scan position
    logic [fb_pkg::pixel_w-1:0] model_mem [3][fb_pkg::frame_px];
    logic [1:0]                 m_write;
    logic [1:0]                 m_ready;
    logic [1:0]                 m_display;
    logic [fb_pkg::coord_w-1:0] sx;
    logic [fb_pkg::coord_w-1:0] sy;

    expect_t exp_q[$];
    expect_t exp_head;
    logic    read_seen;
    int      errors;
    int      checked;
    int      seed_init;

    triple_buffer_codec u_triple_buffer_codec (
        .clk         (clk),
        .rst_n       (rst_n),
        .pixel_in    (pixel_in),
        .wr_en       (wr_en),
        .wr_x        (wr_x),
        .wr_y        (wr_y),
        .buffer_swap (buffer_swap),
        .rd_en       (rd_en),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .out_x       (out_x),
        .out_y       (out_y),
        .frame_start (frame_start),
        .line_start  (line_start)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // row times frame width plus column
    function automatic logic [fb_pkg::addr_w-1:0] raster_index(
        input logic [fb_pkg::coord_w-1:0] x,
        input logic [fb_pkg::coord_w-1:0] y
    );
        int idx;
        idx = int'(y) * fb_pkg::frame_w + int'(x);
        return idx[fb_pkg::addr_w-1:0];
    endfunction

    // one clock of stimulus, mirrored in the model as the DUT will sample it
    task automatic drive_cycle(
        input logic                       we,
        input logic [fb_pkg::coord_w-1:0] x,
        input logic [fb_pkg::coord_w-1:0] y,
        input logic [fb_pkg::pixel_w-1:0] d,
        input logic                       re,
        input logic                       sw
    );
        expect_t    e;
        logic [1:0] old_display;
        @(posedge clk);
        wr_en       <= we;
        wr_x        <= x;
        wr_y        <= y;
        pixel_in    <= d;
        rd_en       <= re;
        buffer_swap <= sw;
        if (re) begin
            read_seen <= 1'b1;
        end
        // a read in the swap cycle is dropped
        if (re && !sw) begin
            e.valid = 1'b1;
            e.x     = sx;
            e.y     = sy;
            e.data  = model_mem[m_display][raster_index(sx, sy)];
            e.fs    = (sx == '0) && (sy == '0);
            e.ls    = (sx == '0);
            exp_q.push_back(e);
            if (int'(sx) == fb_pkg::frame_w - 1) begin
                sx = '0;
                sy = (int'(sy) == fb_pkg::frame_h - 1) ? '0 : sy + 1'b1;
            end else begin
                sx = sx + 1'b1;
            end
        end
        // lands in the bank that was the write bank before any swap
        if (we && int'(x) < fb_pkg::frame_w && int'(y) < fb_pkg::frame_h) begin
            model_mem[m_write][raster_index(x, y)] = d;
        end
        if (sw) begin
            old_display = m_display;
            m_display   = m_ready;
            m_ready     = m_write;
            m_write     = old_display;
            sx          = '0;
            sy          = '0;
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, '0, 1'b0, 1'b0);
    endtask

    task automatic swap_buffers(input logic with_read);
        drive_cycle(1'b0, '0, '0, '0, with_read, 1'b1);
    endtask

    task automatic fill_frame();
        int          x;
        int          y;
        logic [31:0] rnd;
        for (y = 0; y < fb_pkg::frame_h; y++) begin
            for (x = 0; x < fb_pkg::frame_w; x++) begin
                rnd = $urandom;
                drive_cycle(1'b1, x[fb_pkg::coord_w-1:0], y[fb_pkg::coord_w-1:0],
                            rnd[fb_pkg::pixel_w-1:0], 1'b0, 1'b0);
            end
        end
    endtask

    // optional random writes ride along with the reads
    task automatic scan_pixels(input int n, input logic with_writes);
        int          i;
        logic [31:0] rx;
        logic [31:0] ry;
        logic [31:0] rd;
        for (i = 0; i < n; i++) begin
            rx = $urandom % fb_pkg::frame_w;
            ry = $urandom % fb_pkg::frame_h;
            rd = $urandom;
            drive_cycle(with_writes, rx[fb_pkg::coord_w-1:0], ry[fb_pkg::coord_w-1:0],
                        rd[fb_pkg::pixel_w-1:0], 1'b1, 1'b0);
            if ($urandom % 4 == 0) begin
                idle_cycles(1);
            end
        end
    endtask

    task automatic out_of_range_writes(input int n);
        int          i;
        logic [31:0] rx;
        logic [31:0] ry;
        logic [31:0] rd;
        for (i = 0; i < n; i++) begin
            rx = $urandom % coord_span;
            ry = $urandom % coord_span;
            // push one coordinate past the frame edge
            if ($urandom % 2 == 0) begin
                rx = fb_pkg::frame_w + ($urandom % (coord_span - fb_pkg::frame_w));
            end else begin
                ry = fb_pkg::frame_h + ($urandom % (coord_span - fb_pkg::frame_h));
            end
            rd = $urandom;
            drive_cycle(1'b1, rx[fb_pkg::coord_w-1:0], ry[fb_pkg::coord_w-1:0],
                        rd[fb_pkg::pixel_w-1:0], 1'b0, 1'b0);
        end
    endtask

    // head of the queue is the pixel now on the outputs
    always @(negedge clk) begin
        if (pixel_valid && exp_q.size() > 0) begin
            exp_head = exp_q.pop_front();
            checked++;
        end else begin
            exp_head = '0;
        end
    end

    a_quiet_before_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        !read_seen |-> (!pixel_valid && !frame_start && !line_start)
    ) else begin
        errors++;
        $display("error at %0t: output activity before the first read", $time);
    end

    a_flags_with_pixel: assert property (
        @(posedge clk) disable iff (!rst_n)
        !pixel_valid |-> (!frame_start && !line_start)
    ) else begin
        errors++;
        $display("error at %0t: scan flag high without pixel_valid", $time);
    end

    a_read_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        pixel_valid |-> exp_head.valid
    ) else begin
        errors++;
        $display("error at %0t: pixel_valid with no read outstanding", $time);
    end

    a_pixel_data: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pixel_valid && exp_head.valid) |-> (pixel_out == exp_head.data)
    ) else begin
        errors++;
        $display("error at %0t: pixel (%0d,%0d) is %h, expected %h", $time,
                 $sampled(exp_head.x), $sampled(exp_head.y),
                 $sampled(pixel_out), $sampled(exp_head.data));
    end

    a_pixel_coords: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pixel_valid && exp_head.valid) |-> (out_x == exp_head.x && out_y == exp_head.y)
    ) else begin
        errors++;
        $display("error at %0t: position (%0d,%0d), expected (%0d,%0d)", $time,
                 $sampled(out_x), $sampled(out_y), $sampled(exp_head.x), $sampled(exp_head.y));
    end

    a_scan_flags: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pixel_valid && exp_head.valid)
            |-> (frame_start == exp_head.fs && line_start == exp_head.ls)
    ) else begin
        errors++;
        $display("error at %0t: flags fs=%0b ls=%0b, expected fs=%0b ls=%0b", $time,
                 $sampled(frame_start), $sampled(line_start),
                 $sampled(exp_head.fs), $sampled(exp_head.ls));
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired at %0t, the run did not reach its end", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        seed_init   = $urandom(66);
        rst_n       = 1'b0;
        pixel_in    = '0;
        wr_en       = 1'b0;
        wr_x        = '0;
        wr_y        = '0;
        buffer_swap = 1'b0;
        rd_en       = 1'b0;
        read_seen   = 1'b0;
        exp_head    = '0;
        errors      = 0;
        checked     = 0;
        m_display   = 2'd0;
        m_write     = 2'd1;
        m_ready     = 2'd2;
        sx          = '0;
        sy          = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        idle_cycles(5);

        // give every bank defined contents
        repeat (3) begin
            fill_frame();
            swap_buffers(1'b0);
        end

        // full frame, two swaps, then a scan that wraps
        fill_frame();
        swap_buffers(1'b0);
        swap_buffers(1'b0);
        scan_pixels(fb_pkg::frame_px + fb_pkg::frame_w, 1'b0);

        // swaps in mid scan, the second one together with rd_en
        scan_pixels(40, 1'b0);
        swap_buffers(1'b0);
        scan_pixels(20, 1'b0);
        swap_buffers(1'b1);
        scan_pixels(20, 1'b0);

        // dropped writes, then show that bank
        out_of_range_writes(64);
        swap_buffers(1'b0);
        swap_buffers(1'b0);
        scan_pixels(fb_pkg::frame_px, 1'b0);

        // writes behind a running scan appear two swaps later
        scan_pixels(fb_pkg::frame_px, 1'b1);
        swap_buffers(1'b0);
        swap_buffers(1'b0);
        scan_pixels(fb_pkg::frame_px, 1'b0);

        idle_cycles(4);
        a_all_returned: assert (exp_q.size() == 0) else begin
            errors++;
            $display("error at %0t: %0d reads never returned a pixel", $time, exp_q.size());
        end
        $display("summary: %0d pixels checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== triple_buffer_codec.f ====
design/fb_pkg.sv
design/pixel_writer.sv
design/buffer_rotator.sv
design/frame_memory.sv
design/raster_scanner.sv
design/triple_buffer_codec.sv
bench/triple_buffer_codec_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := triple_buffer_codec_tb
FILELIST  := triple_buffer_codec.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass line missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
